// ==== compile.f ====
+incdir+design
design/usb_pkg.sv
design/usb_regs.sv
design/usb_serial_func.sv
design/usb_keyboard_func.sv
design/usb_disk_func.sv
design/usb_periph.sv
sim/usb_properties.sv
sim/usb_checker.sv
sim/usb_tb.sv

// ==== design/usb_consts.svh ====
`ifndef USB_CONSTS_SVH
`define USB_CONSTS_SVH

// register offsets on the 4-bit bus address
`define USB_CCR 4'd0
`define USB_RDR 4'd4
`define USB_TDR 4'd8
`define USB_STA 4'd12

// disk byte ram
`define DISK_AW    12
`define DISK_DEPTH 4096

// bytes per keyboard report
`define KBD_REPORT_LEN 3

`endif

// ==== design/usb_disk_func.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_consts.svh"

module usb_disk_func (
   input  wire logic           clk_i,
   input  wire logic           rst_i,
   input  wire usb_pkg::byte_t host_rx_i,
   output usb_pkg::byte_t      host_tx_o
);

   usb_pkg::disk_state_e state_q;
   usb_pkg::disk_op_e    op_q;
   logic [`DISK_AW-9:0]  addr_hi_q;
   logic [`DISK_AW-1:0]  addr_q;     // held for the data byte of a write
   logic [`DISK_AW-1:0]  ram_addr;
   logic                 ram_we;
   logic [7:0]           ram_rdata_q;
   logic                 rd_pend_q;
   logic                 tx_valid_q;
   logic [7:0]           tx_data_q;
   logic [7:0]           mem [`DISK_DEPTH];

   initial begin
      for (int i = 0; i < `DISK_DEPTH; i++)
         mem[i] = 8'h00;
   end

   assign ram_addr = (state_q == usb_pkg::DATA) ? addr_q : {addr_hi_q, host_rx_i.data};
   assign ram_we   = host_rx_i.valid & (state_q == usb_pkg::DATA);

   always_ff @(posedge clk_i) begin
      if (ram_we)
         mem[ram_addr] <= host_rx_i.data;
      ram_rdata_q <= mem[ram_addr];   // one cycle read latency
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q    <= usb_pkg::IDLE;
         rd_pend_q  <= 1'b0;
         tx_valid_q <= 1'b0;
      end else begin
         rd_pend_q  <= 1'b0;
         tx_valid_q <= rd_pend_q;
         if (host_rx_i.valid) begin
            case (state_q)
               usb_pkg::IDLE: begin
                  if (host_rx_i.data == usb_pkg::DISK_WRITE ||
                      host_rx_i.data == usb_pkg::DISK_READ)
                     state_q <= usb_pkg::ADDR_HI;   // other bytes dropped
               end
               usb_pkg::ADDR_HI: state_q <= usb_pkg::ADDR_LO;
               usb_pkg::ADDR_LO: begin
                  if (op_q == usb_pkg::DISK_READ) begin
                     rd_pend_q <= 1'b1;   // ram read issued this cycle
                     state_q   <= usb_pkg::IDLE;
                  end else begin
                     state_q <= usb_pkg::DATA;
                  end
               end
               default: state_q <= usb_pkg::IDLE;
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (host_rx_i.valid && state_q == usb_pkg::IDLE)
         op_q <= usb_pkg::disk_op_e'(host_rx_i.data);
      if (host_rx_i.valid && state_q == usb_pkg::ADDR_HI)
         addr_hi_q <= host_rx_i.data[`DISK_AW-9:0];   // low nibble only
      if (host_rx_i.valid && state_q == usb_pkg::ADDR_LO)
         addr_q <= ram_addr;
      if (rd_pend_q)
         tx_data_q <= ram_rdata_q;
   end

   assign host_tx_o.valid = tx_valid_q;
   assign host_tx_o.data  = tx_data_q;

endmodule

`default_nettype wire

// ==== design/usb_keyboard_func.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_consts.svh"

module usb_keyboard_func (
   input  wire logic           clk_i,
   input  wire logic           rst_i,
   input  wire usb_pkg::byte_t tdr_wr_i,
   input  wire logic [15:0]    tdr_word_i,
   output usb_pkg::byte_t      host_tx_o
);

   logic [1:0] cnt_q;     // next report byte, 0 when no report is running
   logic [7:0] key_q;
   logic       tx_valid_q;
   logic [7:0] tx_data_q;
   logic       start;

   // busy until the last report byte has left the output register
   assign start = tdr_wr_i.valid & (cnt_q == 2'd0) & ~tx_valid_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q      <= 2'd0;
         tx_valid_q <= 1'b0;
      end else if (cnt_q != 2'd0) begin
         tx_valid_q <= 1'b1;
         if (cnt_q == 2'(`KBD_REPORT_LEN - 1))
            cnt_q <= 2'd0;
         else
            cnt_q <= cnt_q + 2'd1;
      end else if (start) begin
         tx_valid_q <= 1'b1;   // modifier goes out first
         cnt_q      <= 2'd1;
      end else begin
         tx_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         tx_data_q <= tdr_word_i[15:8];
         key_q     <= tdr_word_i[7:0];
      end else if (cnt_q == 2'd1) begin
         tx_data_q <= 8'h00;   // reserved byte
      end else if (cnt_q != 2'd0) begin
         tx_data_q <= key_q;
      end
   end

   assign host_tx_o.valid = tx_valid_q;
   assign host_tx_o.data  = tx_data_q;

endmodule

`default_nettype wire

// ==== design/usb_periph.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_periph (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire usb_pkg::bus_req_t bus_i,
   output logic [31:0]            rdata_o,
   input  wire usb_pkg::byte_t    host_rx_i,
   output usb_pkg::byte_t         host_tx_o,
   output logic                   connected_o
);

   usb_pkg::usb_func_e func_sel;
   usb_pkg::byte_t     tdr_wr;
   logic [15:0]        tdr_word;
   usb_pkg::byte_t     regs_rx;
   logic               sel_serial;
   logic               sel_kbd;
   logic               sel_disk;
   logic [2:0]         func_rst_q;   // {disk, keyboard, serial}
   usb_pkg::byte_t     serial_host_rx;
   usb_pkg::byte_t     disk_host_rx;
   usb_pkg::byte_t     serial_rx;
   usb_pkg::byte_t     serial_tx;
   usb_pkg::byte_t     kbd_tx;
   usb_pkg::byte_t     disk_tx;

   // undefined encodings select nothing
   always_comb begin
      sel_serial = (func_sel == usb_pkg::FUNC_SERIAL);
      sel_kbd    = (func_sel == usb_pkg::FUNC_KEYBOARD);
      sel_disk   = (func_sel == usb_pkg::FUNC_DISK);
   end

   assign connected_o = sel_serial | sel_kbd | sel_disk;

   // a newly selected function stays in reset for the cycle func_sel changes
   always_ff @(posedge clk_i) begin
      if (rst_i)
         func_rst_q <= 3'b111;
      else
         func_rst_q <= ~{sel_disk, sel_kbd, sel_serial};
   end

   // host bytes reach the selected function only
   always_comb begin
      serial_host_rx       = host_rx_i;
      serial_host_rx.valid = host_rx_i.valid & sel_serial;
      disk_host_rx         = host_rx_i;
      disk_host_rx.valid   = host_rx_i.valid & sel_disk;
      regs_rx              = serial_rx;
      regs_rx.valid        = serial_rx.valid & sel_serial;
   end

   always_comb begin
      case (func_sel)
         usb_pkg::FUNC_SERIAL:   host_tx_o = serial_tx;
         usb_pkg::FUNC_KEYBOARD: host_tx_o = kbd_tx;
         usb_pkg::FUNC_DISK:     host_tx_o = disk_tx;
         default:                host_tx_o = '0;
      endcase
   end

   usb_regs u_regs (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .bus_i       (bus_i),
      .rdata_o     (rdata_o),
      .rx_i        (regs_rx),
      .connected_i (connected_o),
      .func_sel_o  (func_sel),
      .tdr_wr_o    (tdr_wr),
      .tdr_word_o  (tdr_word)
   );

   usb_serial_func u_serial (
      .clk_i     (clk_i),
      .rst_i     (rst_i | func_rst_q[0]),
      .host_rx_i (serial_host_rx),
      .tdr_wr_i  (tdr_wr),
      .rx_o      (serial_rx),
      .host_tx_o (serial_tx)
   );

   usb_keyboard_func u_keyboard (
      .clk_i      (clk_i),
      .rst_i      (rst_i | func_rst_q[1]),
      .tdr_wr_i   (tdr_wr),
      .tdr_word_i (tdr_word),
      .host_tx_o  (kbd_tx)
   );

   usb_disk_func u_disk (
      .clk_i     (clk_i),
      .rst_i     (rst_i | func_rst_q[2]),
      .host_rx_i (disk_host_rx),
      .host_tx_o (disk_tx)
   );

endmodule

`default_nettype wire

// ==== design/usb_pkg.sv ====
`default_nettype none

package usb_pkg;

   // active device class, same encoding as the ccr field
   typedef enum logic [2:0] {
      FUNC_NONE     = 3'd0,
      FUNC_SERIAL   = 3'd1,
      FUNC_KEYBOARD = 3'd2,
      FUNC_DISK     = 3'd3
   } usb_func_e;

   // first byte of a disk command
   typedef enum logic [7:0] {
      DISK_WRITE = 8'h01,
      DISK_READ  = 8'h02
   } disk_op_e;

   typedef enum logic [1:0] {
      IDLE,
      ADDR_HI,   // waiting for upper address bits
      ADDR_LO,
      DATA       // write payload byte
   } disk_state_e;

   // one bus access from the processor
   typedef struct packed {
      logic        valid;
      logic        write;
      logic [3:0]  be;      // byte enables
      logic [3:0]  addr;    // byte offset
      logic [31:0] wdata;
   } bus_req_t;

   // single byte strobe, no back-pressure
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } byte_t;

endpackage

`default_nettype wire

// ==== design/usb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_consts.svh"

module usb_regs (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire usb_pkg::bus_req_t bus_i,
   output logic [31:0]            rdata_o,
   input  wire usb_pkg::byte_t    rx_i,
   input  wire logic              connected_i,
   output usb_pkg::usb_func_e     func_sel_o,
   output usb_pkg::byte_t         tdr_wr_o,
   output logic [15:0]            tdr_word_o
);

   logic [2:0]  ccr_q;
   logic [15:0] tdr_q;
   logic        tdr_wr_q;
   logic [7:0]  rdr_q;
   logic        recv_valid_q;
   logic [31:0] rdata_q;
   logic        wr_en;
   logic        rd_en;
   logic        ccr_we;
   logic        tdr_we;
   logic        rdr_rd;
   logic        sta_clr;

   assign wr_en   = bus_i.valid & bus_i.write;
   assign rd_en   = bus_i.valid & ~bus_i.write;
   assign ccr_we  = wr_en & (bus_i.addr == `USB_CCR) & bus_i.be[0];
   assign tdr_we  = wr_en & (bus_i.addr == `USB_TDR);
   assign rdr_rd  = rd_en & (bus_i.addr == `USB_RDR);
   assign sta_clr = wr_en & (bus_i.addr == `USB_STA) & ~bus_i.wdata[1];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ccr_q        <= 3'd0;
         tdr_wr_q     <= 1'b0;
         recv_valid_q <= 1'b0;
      end else begin
         if (ccr_we)
            ccr_q <= bus_i.wdata[2:0];
         tdr_wr_q <= tdr_we & (|bus_i.be[1:0]);   // one strobe per tdr write
         // a fresh byte beats a clear in the same cycle
         if (rx_i.valid)
            recv_valid_q <= 1'b1;
         else if (rdr_rd || sta_clr)
            recv_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (tdr_we && bus_i.be[0])
         tdr_q[7:0] <= bus_i.wdata[7:0];   // serial byte or keycode
      if (tdr_we && bus_i.be[1])
         tdr_q[15:8] <= bus_i.wdata[15:8]; // keyboard modifier
      if (rx_i.valid)
         rdr_q <= rx_i.data;
   end

   // read data holds until the next read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rdata_q <= 32'd0;
      end else if (rd_en) begin
         case (bus_i.addr)
            `USB_CCR: rdata_q <= {29'd0, ccr_q};
            `USB_RDR: rdata_q <= {24'd0, rdr_q};
            `USB_TDR: rdata_q <= {16'd0, tdr_q};
            `USB_STA: rdata_q <= {30'd0, recv_valid_q, connected_i};
            default:  rdata_q <= 32'd0;
         endcase
      end
   end

   assign rdata_o        = rdata_q;
   assign func_sel_o     = usb_pkg::usb_func_e'(ccr_q);
   assign tdr_wr_o.valid = tdr_wr_q;
   assign tdr_wr_o.data  = tdr_q[7:0];
   assign tdr_word_o     = tdr_q;

endmodule

`default_nettype wire

// ==== design/usb_serial_func.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_serial_func (
   input  wire logic           clk_i,
   input  wire logic           rst_i,
   input  wire usb_pkg::byte_t host_rx_i,
   input  wire usb_pkg::byte_t tdr_wr_i,
   output usb_pkg::byte_t      rx_o,
   output usb_pkg::byte_t      host_tx_o
);

   logic       rx_valid_q;
   logic [7:0] rx_data_q;
   logic       tx_valid_q;
   logic [7:0] tx_data_q;

   // both directions run side by side
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rx_valid_q <= 1'b0;
         tx_valid_q <= 1'b0;
      end else begin
         rx_valid_q <= host_rx_i.valid;   // host to software
         tx_valid_q <= tdr_wr_i.valid;    // software to host
      end
   end

   always_ff @(posedge clk_i) begin
      if (host_rx_i.valid)
         rx_data_q <= host_rx_i.data;
      if (tdr_wr_i.valid)
         tx_data_q <= tdr_wr_i.data;
   end

   assign rx_o.valid      = rx_valid_q;
   assign rx_o.data       = rx_data_q;
   assign host_tx_o.valid = tx_valid_q;
   assign host_tx_o.data  = tx_data_q;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the usb peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module usb_tb -f compile.f -o usb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/usb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "test passed"; then
   exit 0
fi
exit 1

// ==== sim/usb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_consts.svh"

module usb_checker (
   input  wire logic              clk_i,
   input  wire logic              rst_i,
   input  wire usb_pkg::bus_req_t bus_i,
   input  wire logic [31:0]       rdata_i,
   input  wire usb_pkg::byte_t    host_rx_i,
   input  wire usb_pkg::byte_t    host_tx_i,
   input  wire logic              connected_i,
   output int                     errors_o,
   output int                     checks_o,
   output int                     pending_o
);

   int                   cyc;
   int                   kbd_ready;    // first strobe cycle a new report is accepted
   logic [2:0]           ccr;
   logic [15:0]          tdr;
   logic [7:0]           rdr;
   logic                 recv_valid;
   logic                 rx_pend;
   logic [7:0]           rx_pend_data;
   logic                 rd_pend;
   logic [31:0]          rd_exp;
   usb_pkg::disk_state_e dst;
   logic [7:0]           dop;
   logic [3:0]           dhi;
   logic [11:0]          daddr;
   logic [7:0]           disk [`DISK_DEPTH];
   int                   exp_cyc [$];  // edge at which each host byte is due
   logic [7:0]           exp_data [$];

   initial begin
      for (int i = 0; i < `DISK_DEPTH; i++)
         disk[i] = 8'h00;
   end

   always @(posedge clk_i) begin : model
      logic wr;
      logic rd;
      logic conn;
      wr   = bus_i.valid & bus_i.write;
      rd   = bus_i.valid & ~bus_i.write;
      conn = (ccr == 3'd1) || (ccr == 3'd2) || (ccr == 3'd3);
      cyc  = cyc + 1;
      if (rst_i) begin
         ccr        = 3'd0;
         recv_valid = 1'b0;
         rx_pend    = 1'b0;
         rd_pend    = 1'b0;
         kbd_ready  = 0;
         dst        = usb_pkg::IDLE;
         errors_o   = 0;
         checks_o   = 0;
         exp_cyc.delete();
         exp_data.delete();
      end else begin
         if (rd_pend) begin
            checks_o++;
            if (rdata_i !== rd_exp) begin
               $display("[ERROR] %0t rdata_o expected %08h got %08h",
                        $time, rd_exp, rdata_i);
               errors_o++;
            end
         end
         checks_o++;
         if (connected_i !== conn) begin
            $display("[ERROR] %0t connected_o expected %0b got %0b",
                     $time, conn, connected_i);
            errors_o++;
         end
         if (host_tx_i.valid) begin
            checks_o++;
            if (exp_cyc.size() == 0 || exp_cyc[0] != cyc) begin
               $display("[ERROR] %0t host_tx_o.valid expected 0 got 1", $time);
               errors_o++;
            end else begin
               if (host_tx_i.data !== exp_data[0]) begin
                  $display("[ERROR] %0t host_tx_o.data expected %02h got %02h",
                           $time, exp_data[0], host_tx_i.data);
                  errors_o++;
               end
               void'(exp_cyc.pop_front());
               void'(exp_data.pop_front());
            end
         end else if (exp_cyc.size() != 0 && exp_cyc[0] == cyc) begin
            $display("%0t: byte %02h was due on host_tx_o but nothing came",
                     $time, exp_data[0]);
            errors_o++;
            void'(exp_cyc.pop_front());
            void'(exp_data.pop_front());
         end

         // read data is what the registers held before this edge
         rd_pend = rd;
         case (bus_i.addr)
            `USB_CCR: rd_exp = {29'd0, ccr};
            `USB_RDR: rd_exp = {24'd0, rdr};
            `USB_TDR: rd_exp = {16'd0, tdr};
            `USB_STA: rd_exp = {30'd0, recv_valid, conn};
            default:  rd_exp = 32'd0;
         endcase

         if (rx_pend && ccr == 3'd1) begin   // new byte wins over a clear
            recv_valid = 1'b1;
            rdr        = rx_pend_data;
         end else if ((rd && bus_i.addr == `USB_RDR) ||
                      (wr && bus_i.addr == `USB_STA && !bus_i.wdata[1])) begin
            recv_valid = 1'b0;
         end
         rx_pend      = host_rx_i.valid && ccr == 3'd1;
         rx_pend_data = host_rx_i.data;

         if (wr && bus_i.addr == `USB_TDR) begin
            if (bus_i.be[0])
               tdr[7:0] = bus_i.wdata[7:0];
            if (bus_i.be[1])
               tdr[15:8] = bus_i.wdata[15:8];
            if (bus_i.be[1:0] != 2'b00 && ccr == 3'd1) begin
               exp_cyc.push_back(cyc + 2);
               exp_data.push_back(tdr[7:0]);
            end
            if (bus_i.be[1:0] != 2'b00 && ccr == 3'd2 && cyc >= kbd_ready) begin
               exp_cyc.push_back(cyc + 2);
               exp_data.push_back(tdr[15:8]);   // modifier
               exp_cyc.push_back(cyc + 3);
               exp_data.push_back(8'h00);
               exp_cyc.push_back(cyc + 4);
               exp_data.push_back(tdr[7:0]);
               kbd_ready = cyc + 4;
            end
         end

         if (host_rx_i.valid && ccr == 3'd3) begin
            case (dst)
               usb_pkg::IDLE: begin
                  dop = host_rx_i.data;
                  if (dop == 8'h01 || dop == 8'h02)
                     dst = usb_pkg::ADDR_HI;
               end
               usb_pkg::ADDR_HI: begin
                  dhi = host_rx_i.data[3:0];
                  dst = usb_pkg::ADDR_LO;
               end
               usb_pkg::ADDR_LO: begin
                  daddr = {dhi, host_rx_i.data};
                  if (dop == 8'h02) begin
                     exp_cyc.push_back(cyc + 2);
                     exp_data.push_back(disk[daddr]);
                     dst = usb_pkg::IDLE;
                  end else begin
                     dst = usb_pkg::DATA;
                  end
               end
               default: begin
                  disk[daddr] = host_rx_i.data;
                  dst = usb_pkg::IDLE;
               end
            endcase
         end

         // a new selection resets the function it lands on
         if (wr && bus_i.addr == `USB_CCR && bus_i.be[0]) begin
            if (bus_i.wdata[2:0] != ccr) begin
               dst       = usb_pkg::IDLE;
               kbd_ready = cyc + 2;
            end
            ccr = bus_i.wdata[2:0];
         end
      end
      pending_o = exp_cyc.size();
   end

endmodule

`default_nettype wire

// ==== sim/usb_properties.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_consts.svh"

module usb_properties (
   input  wire logic               clk_i,
   input  wire logic               rst_i,
   input  wire usb_pkg::bus_req_t  bus_i,
   input  wire usb_pkg::usb_func_e func_sel_i,
   input  wire usb_pkg::byte_t     host_tx_i,
   input  wire logic               connected_i
);

   int   fail_cnt = 0;
   logic ccr_wr;
   logic wr_conn;   // written ccr value names a real function

   assign ccr_wr  = bus_i.valid & bus_i.write & (bus_i.addr == `USB_CCR) & bus_i.be[0];
   assign wr_conn = (bus_i.wdata[2:0] != 3'd0) && (bus_i.wdata[2:0] <= 3'd3);

   a_quiet_when_none: assert property (@(posedge clk_i) disable iff (rst_i)
      (func_sel_i == usb_pkg::FUNC_NONE) |-> !host_tx_i.valid)
      else begin
         fail_cnt++;
         $error("host_tx_o valid while no function is selected");
      end

   // pull-up settles one cycle after a ccr write
   a_connected: assert property (@(posedge clk_i) disable iff (rst_i)
      ccr_wr |=> (connected_i == $past(wr_conn)))
      else begin
         fail_cnt++;
         $error("connected_o does not follow the ccr write");
      end

   a_idle_after_reset: assert property (@(posedge clk_i)
      $fell(rst_i) |-> !host_tx_i.valid)
      else begin
         fail_cnt++;
         $error("host_tx_o valid in the first cycle after reset");
      end

endmodule

`default_nettype wire

// ==== sim/usb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_consts.svh"

module usb_tb;

   localparam int RESET_CYCLES = 16;
   localparam int T_SELECT     = 150;   // rough cycle budgets per test
   localparam int T_SERIAL_RX  = 300;
   localparam int T_SERIAL_TX  = 200;
   localparam int T_KEYBOARD   = 250;
   localparam int T_DISK       = 900;
   localparam int T_SWITCH     = 400;
   localparam int WATCHDOG_NS  = (RESET_CYCLES + T_SELECT + T_SERIAL_RX + T_SERIAL_TX +
                                  T_KEYBOARD + T_DISK + T_SWITCH) * 10 * 2;

   logic              clk;
   logic              rst;
   usb_pkg::bus_req_t bus;
   logic [31:0]       rdata;
   usb_pkg::byte_t    host_rx;
   usb_pkg::byte_t    host_tx;
   logic              connected;
   int                errors;
   int                checks;
   int                pending;
   int                test_errs;
   int                total_errs;
   integer            seed;
   logic [31:0]       r;
   logic [7:0]        op;
   logic [11:0]       a;

   usb_periph u_dut (
      .clk_i       (clk),
      .rst_i       (rst),
      .bus_i       (bus),
      .rdata_o     (rdata),
      .host_rx_i   (host_rx),
      .host_tx_o   (host_tx),
      .connected_o (connected)
   );

   usb_checker u_chk (
      .clk_i       (clk),
      .rst_i       (rst),
      .bus_i       (bus),
      .rdata_i     (rdata),
      .host_rx_i   (host_rx),
      .host_tx_i   (host_tx),
      .connected_i (connected),
      .errors_o    (errors),
      .checks_o    (checks),
      .pending_o   (pending)
   );

   bind usb_periph usb_properties u_props (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .bus_i       (bus_i),
      .func_sel_i  (func_sel),
      .host_tx_i   (host_tx_o),
      .connected_i (connected_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before all tests completed");
      $display("test failed");
      $finish;
   end

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   // one-cycle bus strobe, full byte enables
   task automatic bus_op(input logic wr, input logic [3:0] addr, input logic [31:0] data);
      @(negedge clk);
      bus.valid = 1'b1;
      bus.write = wr;
      bus.be    = 4'hf;
      bus.addr  = addr;
      bus.wdata = data;
      @(negedge clk);
      bus = '0;
   endtask

   task automatic send_host(input logic [7:0] b);
      @(negedge clk);
      host_rx.valid = 1'b1;
      host_rx.data  = b;
      @(negedge clk);
      host_rx = '0;
   endtask

   task automatic disk_cmd(input logic [7:0] dop, input logic [11:0] da, input logic [7:0] dd);
      logic [31:0] g;
      g = $random(seed);
      send_host(dop);
      idle(int'(g[1:0]));
      send_host({g[7:4], da[11:8]});   // upper nibble is don't care
      idle(int'(g[3:2]));
      send_host(da[7:0]);
      if (dop == 8'h01) begin
         idle(int'(g[9:8]));
         send_host(dd);
      end
   endtask

   // waits for every expected host byte, then reports the test
   task automatic end_test(input string name);
      while (pending != 0)
         @(negedge clk);
      idle(3);
      $display("[done] %s errors %0d", name, errors - test_errs);
      test_errs = errors;
   endtask

   initial begin
      seed      = 32'hbdb3;
      bus       = '0;
      host_rx   = '0;
      rst       = 1'b1;
      test_errs = 0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      idle(2);

      bus_op(1'b0, `USB_STA, 32'd0);
      repeat (8) begin
         r = $random(seed);
         bus_op(1'b1, `USB_CCR, {30'd0, r[1:0]});
         idle(4);
         bus_op(1'b0, `USB_CCR, 32'd0);
         bus_op(1'b0, `USB_STA, 32'd0);
      end
      end_test("select");

      bus_op(1'b1, `USB_CCR, 32'd1);
      idle(4);
      repeat (16) begin
         r = $random(seed);
         repeat (int'(r[1:0]) + 1) begin
            r = $random(seed);
            send_host(r[7:0]);
         end
         idle(3);
         bus_op(1'b0, `USB_STA, 32'd0);
         bus_op(1'b0, `USB_RDR, 32'd0);
         bus_op(1'b0, `USB_STA, 32'd0);
      end
      end_test("serial_rx");

      repeat (20) begin
         r = $random(seed);
         bus_op(1'b1, `USB_TDR, r);
         idle(int'(r[9:8]));
      end
      end_test("serial_tx");

      bus_op(1'b1, `USB_CCR, 32'd2);
      idle(4);
      repeat (12) begin
         r = $random(seed);
         bus_op(1'b1, `USB_TDR, r);
         if (r[31])
            bus_op(1'b1, `USB_TDR, ~r);   // lands mid report
         idle(6);
      end
      end_test("keyboard");

      bus_op(1'b1, `USB_CCR, 32'd3);
      idle(4);
      repeat (40) begin
         r  = $random(seed);
         op = r[0] ? 8'h01 : 8'h02;
         a  = {r[11:10], 4'd0, r[21:16]};   // small window so reads hit writes
         if (r[7:4] == 4'h0)
            send_host(8'h5a);
         disk_cmd(op, a, r[31:24]);
      end
      end_test("disk");

      repeat (6) begin
         r = $random(seed);
         a = {r[11:10], 4'd0, r[21:16]};
         disk_cmd(8'h01, a, r[31:24]);
         send_host(8'h02);
         send_host({4'd0, a[11:8]});
         bus_op(1'b1, `USB_CCR, 32'd1);
         idle(4);
         bus_op(1'b1, `USB_CCR, 32'd3);
         idle(4);
         disk_cmd(8'h02, a, 8'h00);
      end
      end_test("switching");

      total_errs = errors + u_dut.u_props.fail_cnt;
      $display("%0d checks, %0d errors", checks, total_errs);
      if (total_errs == 0 && checks > 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire
